// ==== include/exec_defs.svh ====
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// operand and result width.
`define EXEC_XLEN 32

// rv32 major opcodes handled by the execute unit.
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011

`endif

// ==== design/exec_pkg.sv ====
`default_nettype none

`include "exec_defs.svh"

package exec_pkg;

    // operation class coming out of the intake decode.
    typedef enum logic [1:0] {
        LOAD_STORE = 2'b00,
        I_TYPE     = 2'b01,
        B_TYPE     = 2'b10,
        R_TYPE     = 2'b11
    } alu_op_t;

    // base ops are {funct7[5], funct3}, m-extension ops have bit 4 set.
    typedef enum logic [4:0] {
        ADD    = 5'b00000,
        SLL    = 5'b00001,
        SLT    = 5'b00010,
        SLTU   = 5'b00011,
        XOR    = 5'b00100,
        SRL    = 5'b00101,
        OR     = 5'b00110,
        AND    = 5'b00111,
        SUB    = 5'b01000,
        SRA    = 5'b01101,
        MUL    = 5'b10000,
        MULH   = 5'b10001,
        MULHSU = 5'b10010,
        MULHU  = 5'b10011,
        DIV    = 5'b10100,
        DIVU   = 5'b10101,
        REM    = 5'b10110,
        REMU   = 5'b10111
    } alu_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    // one instruction word, three ways to read it.
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
    } instr_u;

    typedef struct packed {
        instr_u                instr;
        logic [`EXEC_XLEN-1:0] rs1_val;
        logic [`EXEC_XLEN-1:0] rs2_val;
    } exec_req_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] result;
        logic                  m_type;
    } exec_rsp_t;

endpackage : exec_pkg

`default_nettype wire

// ==== design/exec_intake.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module exec_intake (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_req,
    input  exec_pkg::exec_req_t   in_data,
    input  logic                  done,
    output logic                  in_ack,
    output logic                  issue,
    output logic [2:0]            funct3,
    output logic [6:0]            funct7,
    output exec_pkg::alu_op_t     alu_op,
    output logic [`EXEC_XLEN-1:0] op_a,
    output logic [`EXEC_XLEN-1:0] op_b
);
    import exec_pkg::*;

    logic                  busy;
    logic                  pending;
    logic                  capture;
    alu_op_t               op_class;
    logic [6:0]            funct7_sel;
    logic [`EXEC_XLEN-1:0] imm_i;
    logic [`EXEC_XLEN-1:0] imm_s;
    logic [`EXEC_XLEN-1:0] op_b_sel;

    // new request only when idle and the last ack has dropped.
    assign capture = in_req & ~in_ack & ~busy;

    assign imm_i = {{(`EXEC_XLEN-12){in_data.instr.i.imm[11]}}, in_data.instr.i.imm};
    assign imm_s = {{(`EXEC_XLEN-12){in_data.instr.s.imm_hi[6]}},
                    in_data.instr.s.imm_hi, in_data.instr.s.imm_lo};

    always_comb begin
        op_class   = LOAD_STORE;
        op_b_sel   = in_data.rs2_val;
        funct7_sel = 7'b0;
        case (in_data.instr.r.opcode)
            `OPC_OP: begin
                op_class   = R_TYPE;
                funct7_sel = in_data.instr.r.funct7;
            end
            // shifts carry their funct7 in the upper immediate bits.
            `OPC_OP_IMM: begin
                op_class   = I_TYPE;
                op_b_sel   = imm_i;
                funct7_sel = in_data.instr.r.funct7;
            end
            `OPC_LOAD:   op_b_sel = imm_i;
            `OPC_STORE:  op_b_sel = imm_s;
            `OPC_BRANCH: op_class = B_TYPE;
            default:     op_class = LOAD_STORE;
        endcase
    end

    // issue and ack follow capture by one cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            pending <= 1'b0;
            issue   <= 1'b0;
            in_ack  <= 1'b0;
        end else begin
            pending <= capture;
            issue   <= pending;
            if (capture) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (pending) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end
        end
    end

    // operands stay put until the next capture.
    always_ff @(posedge clk) begin
        if (capture) begin
            funct3 <= in_data.instr.r.funct3;
            funct7 <= funct7_sel;
            alu_op <= op_class;
            op_a   <= in_data.rs1_val;
            op_b   <= op_b_sel;
        end
    end

endmodule : exec_intake

`default_nettype wire

// ==== design/alu_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_control (
    input  logic [2:0]        fun3,
    input  logic [6:0]        fun7,
    input  exec_pkg::alu_op_t alu_op,
    output exec_pkg::alu_t    alu_ctrl,
    output logic              m_type,
    output logic              divide_instruction
);
    import exec_pkg::*;

    always_comb begin
        alu_ctrl           = ADD;
        m_type             = 1'b0;
        divide_instruction = 1'b0;
        case (alu_op)
            R_TYPE: begin
                // funct7 bit 0 marks the m extension.
                if (fun7[0]) begin
                    m_type = 1'b1;
                    case (fun3)
                        3'b000: alu_ctrl = MUL;
                        3'b001: alu_ctrl = MULH;
                        3'b010: alu_ctrl = MULHSU;
                        3'b011: alu_ctrl = MULHU;
                        3'b100: alu_ctrl = DIV;
                        3'b101: alu_ctrl = DIVU;
                        3'b110: alu_ctrl = REM;
                        default: alu_ctrl = REMU;
                    endcase
                    divide_instruction = fun3[2];
                end else begin
                    alu_ctrl = alu_t'({1'b0, fun7[5], fun3});
                end
            end

            // only srai looks at funct7, addi has no subtract form.
            I_TYPE: begin
                alu_ctrl = alu_t'({1'b0, (fun3 == 3'b101) & fun7[5], fun3});
            end

            // beq/bne compare by subtraction, the rest by set-less-than.
            B_TYPE: begin
                case (fun3[2:1])
                    2'b10:   alu_ctrl = SLT;
                    2'b11:   alu_ctrl = SLTU;
                    default: alu_ctrl = SUB;
                endcase
            end

            // address sum.
            LOAD_STORE: begin
                alu_ctrl = ADD;
            end
        endcase
    end

endmodule : alu_control

`default_nettype wire

// ==== design/int_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module int_alu (
    input  logic [`EXEC_XLEN-1:0] op_a,
    input  logic [`EXEC_XLEN-1:0] op_b,
    input  exec_pkg::alu_t        alu_ctrl,
    input  logic                  m_type,
    output logic [`EXEC_XLEN-1:0] result
);
    import exec_pkg::*;

    localparam int XLEN = `EXEC_XLEN;
    localparam int SHW  = $clog2(XLEN);

    logic [SHW-1:0]         shamt;
    logic                   mul_en;
    logic                   a_signed;
    logic                   b_signed;
    logic signed [XLEN:0]   mul_a;
    logic signed [XLEN:0]   mul_b;
    logic signed [2*XLEN+1:0] product;
    logic [XLEN-1:0]        base_result;

    assign shamt = op_b[SHW-1:0];

    always_comb begin
        case (alu_ctrl)
            ADD:     base_result = op_a + op_b;
            SUB:     base_result = op_a - op_b;
            SLL:     base_result = op_a << shamt;
            SLT:     base_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    base_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            XOR:     base_result = op_a ^ op_b;
            SRL:     base_result = op_a >> shamt;
            SRA:     base_result = $unsigned($signed(op_a) >>> shamt);
            OR:      base_result = op_a | op_b;
            AND:     base_result = op_a & op_b;
            default: base_result = '0;
        endcase
    end

    // multiplier inputs idle at zero outside mul ops.
    assign mul_en   = m_type & ~alu_ctrl[2];
    assign a_signed = (alu_ctrl[1:0] != 2'b11);
    assign b_signed = ~alu_ctrl[1];
    assign mul_a    = mul_en ? {a_signed & op_a[XLEN-1], op_a} : '0;
    assign mul_b    = mul_en ? {b_signed & op_b[XLEN-1], op_b} : '0;
    assign product  = mul_a * mul_b;

    // mul returns the low word, the mulh variants the high word.
    always_comb begin
        if (m_type) begin
            result = (alu_ctrl[1:0] == 2'b00) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
        end else begin
            result = base_result;
        end
    end

endmodule : int_alu

`default_nettype wire

// ==== design/serial_divider.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module serial_divider (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  exec_pkg::alu_t        op,
    input  logic [`EXEC_XLEN-1:0] dividend,
    input  logic [`EXEC_XLEN-1:0] divisor,
    output logic                  div_done,
    output logic [`EXEC_XLEN-1:0] quotient,
    output logic [`EXEC_XLEN-1:0] remainder
);
    localparam int XLEN  = `EXEC_XLEN;
    localparam int CNT_W = $clog2(XLEN);

    logic             running;
    logic             fixup;
    logic [CNT_W-1:0] count;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  quo_q;
    logic [XLEN-1:0]  dvs_q;
    logic             quo_neg;
    logic             rem_neg;
    logic             dvz;
    logic             is_signed;
    logic [XLEN-1:0]  dvd_mag;
    logic [XLEN-1:0]  dvs_mag;
    logic [XLEN:0]    rem_shift;
    logic [XLEN+1:0]  diff;

    // div and rem are the signed forms, funct3 bit 0 clear.
    assign is_signed = ~op[0];
    assign dvd_mag   = (is_signed && dividend[XLEN-1]) ? -dividend : dividend;
    assign dvs_mag   = (is_signed && divisor[XLEN-1]) ? -divisor : divisor;

    // one restoring step: shift in the next dividend bit, trial subtract.
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign diff      = {1'b0, rem_shift} - {2'b00, dvs_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running  <= 1'b0;
            fixup    <= 1'b0;
            count    <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (count == CNT_W'(XLEN-1)) begin
                    running <= 1'b0;
                    fixup   <= 1'b1;
                end
            end else if (fixup) begin
                fixup    <= 1'b0;
                div_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q   <= '0;
            quo_q   <= dvd_mag;
            dvs_q   <= dvs_mag;
            quo_neg <= is_signed & (dividend[XLEN-1] ^ divisor[XLEN-1]);
            rem_neg <= is_signed & dividend[XLEN-1];
            dvz     <= (divisor == '0);
        end else if (running) begin
            if (!diff[XLEN+1]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end else if (fixup) begin
            // zero divisor leaves the dividend as remainder already.
            // most-negative by -1 comes out as the dividend with rem 0.
            quotient  <= dvz ? '1 : (quo_neg ? -quo_q : quo_q);
            remainder <= rem_neg ? -rem_q : rem_q;
        end
    end

endmodule : serial_divider

`default_nettype wire

// ==== design/exec_result.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module exec_result (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  issue,
    input  logic                  divide_instruction,
    input  logic                  m_type,
    input  logic                  div_done,
    input  exec_pkg::alu_t        op,
    input  logic [`EXEC_XLEN-1:0] alu_result,
    input  logic [`EXEC_XLEN-1:0] quotient,
    input  logic [`EXEC_XLEN-1:0] remainder,
    input  logic                  out_ack,
    output logic                  out_req,
    output logic                  done,
    output exec_pkg::exec_rsp_t   out_data
);
    logic                  load;
    logic                  releasing;
    logic [`EXEC_XLEN-1:0] result_sel;

    assign load = (issue & ~divide_instruction) | div_done;

    // rem and remu have funct3 bit 1 set.
    assign result_sel = div_done ? (op[1] ? remainder : quotient) : alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_req   <= 1'b0;
            releasing <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load) begin
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                out_req   <= 1'b0;
                releasing <= 1'b1;
            end
            // handshake closes once the consumer drops ack.
            if (releasing && !out_ack) begin
                releasing <= 1'b0;
                done      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data.result <= result_sel;
            out_data.m_type <= m_type;
        end
    end

endmodule : exec_result

`default_nettype wire

// ==== design/exec_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module exec_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_req,
    input  exec_pkg::exec_req_t in_data,
    output logic                in_ack,
    output logic                out_req,
    output exec_pkg::exec_rsp_t out_data,
    input  logic                out_ack
);
    import exec_pkg::*;

    logic                  issue;
    logic                  done;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    alu_op_t               alu_op;
    alu_t                  alu_ctrl;
    logic                  m_type;
    logic                  divide_instruction;
    logic [`EXEC_XLEN-1:0] op_a;
    logic [`EXEC_XLEN-1:0] op_b;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic                  div_done;
    logic [`EXEC_XLEN-1:0] quotient;
    logic [`EXEC_XLEN-1:0] remainder;

    exec_intake u_exec_intake (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_req  (in_req),
        .in_data (in_data),
        .done    (done),
        .in_ack  (in_ack),
        .issue   (issue),
        .funct3  (funct3),
        .funct7  (funct7),
        .alu_op  (alu_op),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    alu_control u_alu_control (
        .fun3               (funct3),
        .fun7               (funct7),
        .alu_op             (alu_op),
        .alu_ctrl           (alu_ctrl),
        .m_type             (m_type),
        .divide_instruction (divide_instruction)
    );

    int_alu u_int_alu (
        .op_a     (op_a),
        .op_b     (op_b),
        .alu_ctrl (alu_ctrl),
        .m_type   (m_type),
        .result   (alu_result)
    );

    // divider only runs for div/rem.
    serial_divider u_serial_divider (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (issue & divide_instruction),
        .op        (alu_ctrl),
        .dividend  (op_a),
        .divisor   (op_b),
        .div_done  (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    exec_result u_exec_result (
        .clk                (clk),
        .arst_n             (arst_n),
        .issue              (issue),
        .divide_instruction (divide_instruction),
        .m_type             (m_type),
        .div_done           (div_done),
        .op                 (alu_ctrl),
        .alu_result         (alu_result),
        .quotient           (quotient),
        .remainder          (remainder),
        .out_ack            (out_ack),
        .out_req            (out_req),
        .done               (done),
        .out_data           (out_data)
    );

endmodule : exec_unit

`default_nettype wire

// ==== test/exec_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module exec_unit_tb;
    import exec_pkg::*;

    localparam int N_OPS          = 400;
    localparam int TIMEOUT_CYCLES = N_OPS * 50;
    localparam int SEED           = 38659;

    typedef struct packed {
        exec_rsp_t rsp;
        logic      is_div;
    } exp_item_t;

    logic      clk;
    logic      arst_n;
    logic      in_req;
    exec_req_t in_data;
    logic      in_ack;
    logic      out_req;
    exec_rsp_t out_data;
    logic      out_ack;

    exp_item_t exp_q[$];
    exp_item_t exp_front;
    int        exp_cnt;
    int        req_cnt;
    int        accept_cnt;
    int        close_cnt;
    int        cycle_cnt;
    int        mismatch_errs;
    int        protocol_errs;

    exec_unit u_exec_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d responses completed",
                     cycle_cnt, close_cnt, req_cnt);
            $display("errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] base_result(input logic [2:0] f3, input logic alt,
                                                input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << sh;
            3'b010:  r = {31'b0, $signed(a) < $signed(b)};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            // arithmetic form fills from the sign bit.
            3'b101:  r = (a >> sh) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] m_ext_result(input logic [2:0] f3, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [63:0]        p;
        logic [31:0]        r;
        sa = a;
        sb = b;
        p  = '0;
        r  = '0;
        if (!f3[2]) begin
            case (f3[1:0])
                2'b00:   p = {32'b0, a} * {32'b0, b};
                2'b01:   p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                2'b10:   p = {{32{a[31]}}, a} * {32'b0, b};
                default: p = {32'b0, a} * {32'b0, b};
            endcase
            r = (f3[1:0] == 2'b00) ? p[31:0] : p[63:32];
        end else if (b == 32'h0) begin
            r = f3[1] ? a : 32'hFFFF_FFFF;
        end else if (!f3[0] && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
            // signed overflow.
            r = f3[1] ? 32'h0 : a;
        end else begin
            case (f3[1:0])
                2'b00:   r = sa / sb;
                2'b01:   r = a / b;
                2'b10:   r = sa % sb;
                default: r = a % b;
            endcase
        end
        return r;
    endfunction

    function automatic exec_rsp_t expect_rsp(input exec_req_t req);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        exec_rsp_t   rsp;
        w     = req.instr;
        a     = req.rs1_val;
        b     = req.rs2_val;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        rsp   = '0;
        case (w[6:0])
            `OPC_OP: begin
                rsp.m_type = w[25];
                rsp.result = w[25] ? m_ext_result(w[14:12], a, b)
                                   : base_result(w[14:12], w[30], a, b);
            end
            // only the right shift reads the alternate bit.
            `OPC_OP_IMM: rsp.result = base_result(w[14:12], w[30] && (w[14:12] == 3'b101),
                                                  a, imm_i);
            `OPC_LOAD:   rsp.result = a + imm_i;
            `OPC_STORE:  rsp.result = a + imm_s;
            `OPC_BRANCH: begin
                case (w[14:13])
                    2'b10:   rsp.result = base_result(3'b010, 1'b0, a, b);
                    2'b11:   rsp.result = base_result(3'b011, 1'b0, a, b);
                    default: rsp.result = a - b;
                endcase
            end
            default: rsp.result = '0;
        endcase
        return rsp;
    endfunction

    function automatic logic [31:0] rand_operand();
        logic [31:0] v;
        case ($urandom_range(0, 7))
            0:       v = 32'h8000_0000;
            1:       v = 32'hFFFF_FFFF;
            2:       v = $urandom_range(0, 15);
            3:       v = $urandom >> $urandom_range(0, 31);
            default: v = $urandom;
        endcase
        return v;
    endfunction

    function automatic instr_u r_type_word(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), `OPC_OP};
    endfunction

    function automatic instr_u i_type_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm, 5'($urandom), f3, 5'($urandom), opc};
    endfunction

    function automatic instr_u store_word(input logic [11:0] imm);
        return {imm[11:5], 5'($urandom), 5'($urandom), 3'b010, imm[4:0], `OPC_STORE};
    endfunction

    function automatic instr_u branch_word(input logic [2:0] f3);
        return {7'($urandom), 5'($urandom), 5'($urandom), f3, 5'($urandom), `OPC_BRANCH};
    endfunction

    task automatic refresh_front();
        exp_cnt   = exp_q.size();
        exp_front = (exp_cnt > 0) ? exp_q[0] : '0;
    endtask

    // starts and returns on a falling edge with in_ack low.
    task automatic send_request(input instr_u instr, input logic [31:0] a,
                                input logic [31:0] b);
        exec_req_t req;
        exp_item_t item;
        req.instr   = instr;
        req.rs1_val = a;
        req.rs2_val = b;
        item.rsp    = expect_rsp(req);
        item.is_div = (instr.r.opcode == `OPC_OP) && instr.r.funct7[0] && instr.r.funct3[2];
        exp_q.push_back(item);
        refresh_front();
        in_data = req;
        in_req  = 1'b1;
        req_cnt++;
        do begin
            @(negedge clk);
        end while (!in_ack);
        accept_cnt++;
        in_req  = 1'b0;
        // scrambled bus shows up a late capture.
        in_data = {$urandom, $urandom, $urandom};
        do begin
            @(negedge clk);
        end while (in_ack);
    endtask

    task automatic run_directed();
        logic [31:0] edge_vals [4] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h1};
        for (int k = 0; k < 8; k++) begin
            send_request(r_type_word(7'h00, 3'(k)), rand_operand(), rand_operand());
        end
        send_request(r_type_word(7'h20, 3'b000), rand_operand(), rand_operand());
        send_request(r_type_word(7'h20, 3'b101), 32'h8765_4321, 32'd12);
        // srai and srli differ only in immediate bit 10.
        send_request(i_type_word({7'h20, 5'd9}, 3'b101, `OPC_OP_IMM), 32'h8000_1234, $urandom);
        send_request(i_type_word({7'h00, 5'd9}, 3'b101, `OPC_OP_IMM), 32'h8000_1234, $urandom);
        send_request(i_type_word({7'h20, 5'd31}, 3'b101, `OPC_OP_IMM), 32'hF000_0000, $urandom);
        send_request(i_type_word({7'h00, 5'd4}, 3'b001, `OPC_OP_IMM), $urandom, $urandom);
        send_request(i_type_word(12'hFF0, 3'b000, `OPC_OP_IMM), 32'd5, $urandom);
        send_request(i_type_word(12'hFFF, 3'b010, `OPC_OP_IMM), 32'h8000_0000, $urandom);
        send_request(i_type_word(12'hFFF, 3'b011, `OPC_OP_IMM), 32'd5, $urandom);
        send_request(i_type_word(12'h800, 3'b100, `OPC_OP_IMM), $urandom, $urandom);
        send_request(i_type_word(12'hF0F, 3'b110, `OPC_OP_IMM), $urandom, $urandom);
        send_request(i_type_word(12'h8F0, 3'b111, `OPC_OP_IMM), $urandom, $urandom);
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    send_request(r_type_word(7'h01, 3'(k)), edge_vals[i], edge_vals[j]);
                end
            end
        end
        // zero divisor, overflow, and a plain signed case.
        for (int k = 4; k < 8; k++) begin
            send_request(r_type_word(7'h01, 3'(k)), $urandom, 32'h0);
            send_request(r_type_word(7'h01, 3'(k)), 32'h8000_0000, 32'hFFFF_FFFF);
            send_request(r_type_word(7'h01, 3'(k)), 32'hFFFF_FFF9, 32'h0000_0002);
        end
        send_request(i_type_word(12'hFFC, 3'b010, `OPC_LOAD), 32'h0000_1000, $urandom);
        send_request(store_word(12'h801), 32'h0000_1000, $urandom);
        send_request(store_word(12'h07F), $urandom, $urandom);
        for (int k = 0; k < 8; k++) begin
            if (k != 2 && k != 3) begin
                send_request(branch_word(3'(k)), rand_operand(), rand_operand());
            end
        end
    endtask

    task automatic run_random_op();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        f3  = 3'($urandom);
        imm = 12'($urandom);
        case ($urandom_range(0, 5))
            0: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1)) ? 7'h20 : 7'h00;
                send_request(r_type_word(f7, f3), rand_operand(), rand_operand());
            end
            1: begin
                // shift immediates keep legal upper bits.
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == 3'b101) begin
                    imm[11:5] = {1'b0, imm[10], 5'b0};
                end
                send_request(i_type_word(imm, f3, `OPC_OP_IMM), rand_operand(), $urandom);
            end
            2: send_request(r_type_word(7'h01, {1'b0, f3[1:0]}), rand_operand(), rand_operand());
            3: send_request(r_type_word(7'h01, {1'b1, f3[1:0]}), rand_operand(), rand_operand());
            4: begin
                if (f3[0]) begin
                    send_request(store_word(imm), rand_operand(), $urandom);
                end else begin
                    send_request(i_type_word(imm, 3'b010, `OPC_LOAD), rand_operand(), $urandom);
                end
            end
            default: begin
                f3 = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
                send_request(branch_word(f3), rand_operand(), rand_operand());
            end
        endcase
    endtask

    assert property (@(posedge clk) !arst_n |-> !in_ack && !out_req)
    else begin
        protocol_errs++;
        $display("in_ack or out_req was high during reset at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> out_data.result == exp_front.rsp.result)
    else begin
        mismatch_errs++;
        $display("Mismatch at %0t: result %h, expected %h", $time,
                 $sampled(out_data.result), $sampled(exp_front.rsp.result));
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> out_data.m_type == exp_front.rsp.m_type)
    else begin
        mismatch_errs++;
        $display("Mismatch at %0t: m_type %b, expected %b", $time,
                 $sampled(out_data.m_type), $sampled(exp_front.rsp.m_type));
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> exp_cnt != 0)
    else begin
        protocol_errs++;
        $display("a response appeared at %0t with no request outstanding", $time);
    end

    // capture edge is one clock before in_ack rises.
    assert property (@(posedge clk) disable iff (!arst_n)
        $past(in_ack) && !$past(in_ack, 2) && !exp_front.is_div |-> $rose(out_req))
    else begin
        protocol_errs++;
        $display("out_req did not rise two cycles after capture at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        out_req && $past(out_req) |-> $stable(out_data))
    else begin
        protocol_errs++;
        $display("out_data changed while out_req was high at %0t", $time);
    end

    // accept_cnt already holds the ack seen on the last falling edge.
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> accept_cnt == close_cnt + 1)
    else begin
        protocol_errs++;
        $display("in_ack rose at %0t before the last response handshake closed", $time);
    end

    initial begin : consumer
        int delay;
        forever begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                delay = $urandom_range(0, 5);
                repeat (delay) begin
                    @(negedge clk);
                end
                out_ack = 1'b1;
                while (out_req) begin
                    @(negedge clk);
                end
                out_ack = 1'b0;
                if (exp_q.size() > 0) begin
                    exp_q.delete(0);
                end
                refresh_front();
                close_cnt++;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        in_req    = 1'b0;
        in_data   = '0;
        out_ack   = 1'b0;
        arst_n    = 1'b0;
        exp_front = '0;
        repeat (8) begin
            @(negedge clk);
        end
        arst_n = 1'b1;
        @(negedge clk);
        run_directed();
        while (req_cnt < N_OPS) begin
            run_random_op();
        end
        while (close_cnt < req_cnt) begin
            @(negedge clk);
        end
        repeat (20) begin
            @(negedge clk);
        end
        assert (!out_req && close_cnt == N_OPS && exp_q.size() == 0)
        else begin
            protocol_errs++;
            $display("responses were missing or extra at the end of the run");
        end
        $display("errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
        if (mismatch_errs == 0 && protocol_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : exec_unit_tb

`default_nettype wire

// ==== vlog.f ====
+incdir+include
design/exec_pkg.sv
design/exec_intake.sv
design/alu_control.sv
design/int_alu.sv
design/serial_divider.sv
design/exec_result.sv
design/exec_unit.sv
test/exec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

export_include_dirs:
  - include

sources:
  - files:
      - design/exec_pkg.sv
      - design/exec_intake.sv
      - design/alu_control.sv
      - design/int_alu.sv
      - design/serial_divider.sv
      - design/exec_result.sv
      - design/exec_unit.sv
  - target: test
    files:
      - test/exec_unit_tb.sv
